// File: videoDmaPkg.sv
// Video DMA shared package with data widths, sizes, bus structs and register map
`default_nettype none

package videoDmaPkg;

	// ------------------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------------------
	typedef logic [15:0] pixel_t;       // One pixel word
	typedef logic [18:0] memAddr_t;     // Memory word address
	typedef logic [18:0] frameLen_t;    // Frame length in words
	typedef logic [3:0]  credit_t;      // Sink credit count
	typedef logic [2:0]  regAddr_t;     // Register index
	typedef logic [31:0] regData_t;     // Register word

	// ------------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------------
	localparam int fifoDepth     = 16;
	localparam int fifoPtrW      = $clog2(fifoDepth);
	localparam int creditMax     = 8;     // Credits held after reset
	localparam int memWords      = 1024;  // RAM model size
	localparam int memIdxW       = $clog2(memWords);
	localparam int refreshPeriod = 64;    // Refresh repeats every 64 cycles
	localparam int refreshCycles = 4;     // Ready low at start of period
	localparam int refreshW      = $clog2(refreshPeriod);

	// Register map
	localparam regAddr_t regCtrl     = 3'd0;  // Bit 0 enable
	localparam regAddr_t regBase0    = 3'd1;
	localparam regAddr_t regBase1    = 3'd2;
	localparam regAddr_t regFrameLen = 3'd3;
	localparam regAddr_t regStatus   = 3'd4;  // Read only

	// ------------------------------------------------------------------------
	// Bundles
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic     valid;
		logic     cmd;     // High read, low write
		memAddr_t addr;
		pixel_t   wdata;
	} ufiReq_t;

	typedef struct packed {
		logic   rvalid;
		pixel_t rdata;
	} ufiResp_t;

	typedef struct packed {
		logic   valid;
		pixel_t data;
	} pixelBeat_t;

	typedef struct packed {
		logic      enable;
		memAddr_t  base0;
		memAddr_t  base1;
		frameLen_t frameLen;
	} dmaCfg_t;

	typedef struct packed {
		logic       writeSel;    // Buffer being filled
		logic       readSel;     // Buffer being scanned out
		logic [7:0] frameCount;  // Completed frames
	} dmaStatus_t;

	// Engine arbitration, last grant given
	typedef enum logic [1:0] {
		grantNone,
		grantWrite,
		grantRead
	} arbGrant_e;

endpackage

`default_nettype wire

// File: pixelWriteFifo.sv
// Pixel write FIFO, show-ahead, with full flag back to the producer
`timescale 1ns/1ps
`default_nettype none

module pixelWriteFifo
	import videoDmaPkg::*;
(
	input  wire             iClk,
	input  wire             rstN,
	input  wire pixelBeat_t pixIn,   // Producer beat
	input  wire             pop,     // Engine takes head word
	output logic            full,    // Producer must stall
	output logic            empty,
	output pixel_t          data     // Head word, valid while not empty
);

	pixel_t              mem [fifoDepth];  // Storage, no reset
	logic [fifoPtrW-1:0] wrPtr;
	logic [fifoPtrW-1:0] rdPtr;
	logic [fifoPtrW:0]   count;            // Occupancy, one bit wider than pointers
	logic                push;
	logic                popOk;

	// ------------------------------------------------------------------------
	// Flags and qualified strobes
	// ------------------------------------------------------------------------
	assign full  = (count == (fifoPtrW + 1)'(fifoDepth));
	assign empty = (count == '0);
	assign push  = pixIn.valid && !full;   // Beat offered while full is lost
	assign popOk = pop && !empty;          // Pop on empty ignored
	assign data  = mem[rdPtr];             // Show-ahead

	always_ff @(posedge iClk)
	begin
		if (push)
			mem[wrPtr] <= pixIn.data;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (popOk)
				rdPtr <= rdPtr + 1'b1;
			case ({push, popOk})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Idle or both
			endcase
		end
	end

endmodule

`default_nettype wire

// File: dmaConfigRegs.sv
// DMA register block with enable, buffer bases, frame length and status read-back
`timescale 1ns/1ps
`default_nettype none

module dmaConfigRegs
	import videoDmaPkg::*;
(
	input  wire             iClk,
	input  wire             rstN,
	input  wire             regWe,     // Write strobe
	input  wire regAddr_t   regAddr,
	input  wire regData_t   regWdata,
	output regData_t        regRdata,  // Combinational read-back
	output dmaCfg_t         cfg,       // Live settings to engine
	input  wire dmaStatus_t status     // Engine state
);

	// ------------------------------------------------------------------------
	// Register writes
	// ------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cfg <= '0;                 // Engine disabled
		end
		else if (regWe)
		begin
			case (regAddr)
				regCtrl:
				begin
					cfg.enable <= regWdata[0];
				end
				regBase0:
				begin
					cfg.base0 <= memAddr_t'(regWdata);
				end
				regBase1:
				begin
					cfg.base1 <= memAddr_t'(regWdata);
				end
				regFrameLen:
				begin
					cfg.frameLen <= frameLen_t'(regWdata);
				end
				default:
				begin
					cfg <= cfg;        // Status and unknown indices
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Read-back mux
	// ------------------------------------------------------------------------
	always_comb
	begin
		case (regAddr)
			regCtrl:     regRdata = regData_t'(cfg.enable);
			regBase0:    regRdata = regData_t'(cfg.base0);
			regBase1:    regRdata = regData_t'(cfg.base1);
			regFrameLen: regRdata = regData_t'(cfg.frameLen);
			regStatus:
			begin
				// Frame count 15:8, read select 1, write select 0
				regRdata = {16'd0, status.frameCount, 6'd0,
					status.readSel, status.writeSel};
			end
			default:     regRdata = '0;  // Unmapped
		endcase
	end

endmodule

`default_nettype wire

// File: videoDmaEngine.sv
// Frame-buffer DMA engine, arbitrates pixel writes and credit-gated reads onto UFI
`timescale 1ns/1ps
`default_nettype none

module videoDmaEngine
	import videoDmaPkg::*;
(
	input  wire            iClk,
	input  wire            rstN,
	input  wire dmaCfg_t   cfg,           // From register block
	output dmaStatus_t     status,        // Buffer selects and frame count
	input  wire pixel_t    fifoData,      // Show-ahead head word
	input  wire            fifoEmpty,
	output logic           fifoPop,       // High in the cycle a write is granted
	output ufiReq_t        ufiReq,        // UFI master request
	input  wire            ufiReady,      // Low during refresh
	input  wire ufiResp_t  ufiResp,
	output pixelBeat_t     pixOut,        // Toward display sink
	input  wire            creditReturn   // One credit per pulse
);

	credit_t   credits;     // Reads the sink can still absorb
	arbGrant_e arbGrant;    // Last grant given
	arbGrant_e grant;       // Grant for this cycle
	frameLen_t wrCnt;       // Word index in write frame
	frameLen_t rdCnt;       // Word index in read frame
	frameLen_t wrNext;
	frameLen_t rdNext;
	memAddr_t  wrBase;
	memAddr_t  rdBase;
	logic      reqFree;     // Request slot free this cycle
	logic      wrPend;
	logic      rdPend;
	logic      rdSel;       // Buffer for the read being issued
	logic      refund;      // Read data dropped while disabled

	// ------------------------------------------------------------------------
	// Request conditions
	// ------------------------------------------------------------------------
	assign reqFree = !ufiReq.valid || ufiReady;  // Empty or leaving this edge
	assign wrPend  = cfg.enable && !fifoEmpty;
	assign rdPend  = cfg.enable && (credits != '0) && (status.frameCount != '0);

	assign wrNext = wrCnt + 1'b1;
	assign rdNext = rdCnt + 1'b1;

	// Frame start picks the buffer not being written
	assign rdSel  = (rdCnt == '0) ? !status.writeSel : status.readSel;
	assign wrBase = status.writeSel ? cfg.base1 : cfg.base0;
	assign rdBase = rdSel ? cfg.base1 : cfg.base0;

	// Data of reads in flight at disable never reaches the sink, so its
	// credit comes straight back
	assign refund = ufiResp.rvalid && !cfg.enable;

	// Alternate when both sides want the port, writes never starve
	always_comb
	begin
		grant = grantNone;
		if (reqFree)
		begin
			if (wrPend && rdPend)
				grant = (arbGrant == grantWrite) ? grantRead : grantWrite;
			else if (wrPend)
				grant = grantWrite;
			else if (rdPend)
				grant = grantRead;
		end
	end

	assign fifoPop = (grant == grantWrite);  // Head word latched below

	// ------------------------------------------------------------------------
	// UFI request register, held while ready is low
	// ------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ufiReq <= '0;
		end
		else if (reqFree)
		begin
			ufiReq.valid <= (grant != grantNone);
			ufiReq.cmd   <= (grant == grantRead);
			ufiReq.addr  <= (grant == grantRead) ? rdBase + rdCnt : wrBase + wrCnt;
			ufiReq.wdata <= fifoData;            // Don't care on reads
		end
	end

	// ------------------------------------------------------------------------
	// Frame sequencing and status
	// ------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrCnt  <= '0;
			rdCnt  <= '0;
			status <= '0;
		end
		else if (!cfg.enable)
		begin
			wrCnt  <= '0;                        // Back to buffer 0, no frames
			rdCnt  <= '0;
			status <= '0;
		end
		else if (grant == grantWrite)
		begin
			if (wrNext == cfg.frameLen)
			begin
				wrCnt             <= '0;         // Frame done, swap buffers
				status.writeSel   <= !status.writeSel;
				status.frameCount <= status.frameCount + 8'd1;
			end
			else
			begin
				wrCnt <= wrNext;
			end
		end
		else if (grant == grantRead)
		begin
			status.readSel <= rdSel;             // Latched at frame start
			if (rdNext == cfg.frameLen)
				rdCnt <= '0;
			else
				rdCnt <= rdNext;
		end
	end

	// ------------------------------------------------------------------------
	// Credits and arbitration history
	// ------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			credits <= credit_t'(creditMax);
		else
			credits <= credits - credit_t'(grant == grantRead)
				+ credit_t'(creditReturn) + credit_t'(refund);
	end

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			arbGrant <= grantNone;
		else if (!cfg.enable)
			arbGrant <= grantNone;
		else if (grant != grantNone)
			arbGrant <= grant;                   // Remember winner
	end

	// Output register, second cycle of read latency
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pixOut <= '0;
		end
		else
		begin
			pixOut.valid <= ufiResp.rvalid && cfg.enable;
			pixOut.data  <= ufiResp.rdata;
		end
	end

endmodule

`default_nettype wire

// File: ufiFrameRam.sv
// UFI frame memory slave, one-cycle read latency and periodic refresh stalls
`timescale 1ns/1ps
`default_nettype none

module ufiFrameRam
	import videoDmaPkg::*;
(
	input  wire          iClk,
	input  wire          rstN,
	input  wire ufiReq_t ufiReq,
	output logic         ufiReady,  // Low while refreshing
	output ufiResp_t     ufiResp
);

	pixel_t              mem [memWords];  // Contents survive reset
	logic [refreshW-1:0] refreshCnt;      // Free running, wraps each period
	logic [memIdxW-1:0]  idx;
	logic                accept;
	logic                rvalidQ;
	pixel_t              rdataQ;

	assign ufiReady = (refreshCnt >= refreshW'(refreshCycles));
	assign idx      = ufiReq.addr[memIdxW-1:0];  // Upper address bits unused
	assign accept   = ufiReq.valid && ufiReady;
	assign ufiResp  = '{rvalid: rvalidQ, rdata: rdataQ};

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			refreshCnt <= '0;
		else
			refreshCnt <= refreshCnt + 1'b1;
	end

	// Single port, one access per accepted request
	always_ff @(posedge iClk)
	begin
		if (accept && !ufiReq.cmd)
			mem[idx] <= ufiReq.wdata;
		if (accept && ufiReq.cmd)
			rdataQ <= mem[idx];
	end

	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			rvalidQ <= 1'b0;
		else
			rvalidQ <= accept && ufiReq.cmd;  // Data one cycle after accept
	end

endmodule

`default_nettype wire

// File: videoDmaTop.sv
// Video DMA top level joining pixel FIFO, registers, DMA engine and frame RAM
`timescale 1ns/1ps
`default_nettype none

module videoDmaTop
	import videoDmaPkg::*;
(
	input  wire             iClk,
	input  wire             rstN,
	input  wire pixelBeat_t pixIn,        // Producer side
	output logic            pixInFull,
	input  wire             regWe,        // Register port
	input  wire regAddr_t   regAddr,
	input  wire regData_t   regWdata,
	output regData_t        regRdata,
	output pixelBeat_t      pixOut,       // Sink side
	input  wire             creditReturn
);

	// ------------------------------------------------------------------------
	// Internal nets
	// ------------------------------------------------------------------------
	pixel_t     fifoData;
	logic       fifoEmpty;
	logic       fifoPop;
	dmaCfg_t    cfg;
	dmaStatus_t status;
	ufiReq_t    ufiReq;
	logic       ufiReady;
	ufiResp_t   ufiResp;

	pixelWriteFifo fifo_i (
		.iClk  (iClk),
		.rstN  (rstN),
		.pixIn (pixIn),
		.pop   (fifoPop),
		.full  (pixInFull),
		.empty (fifoEmpty),
		.data  (fifoData)
	);

	dmaConfigRegs regs_i (
		.iClk     (iClk),
		.rstN     (rstN),
		.regWe    (regWe),
		.regAddr  (regAddr),
		.regWdata (regWdata),
		.regRdata (regRdata),
		.cfg      (cfg),
		.status   (status)
	);

	videoDmaEngine engine_i (
		.iClk         (iClk),
		.rstN         (rstN),
		.cfg          (cfg),
		.status       (status),
		.fifoData     (fifoData),
		.fifoEmpty    (fifoEmpty),
		.fifoPop      (fifoPop),
		.ufiReq       (ufiReq),
		.ufiReady     (ufiReady),
		.ufiResp      (ufiResp),
		.pixOut       (pixOut),
		.creditReturn (creditReturn)
	);

	// Memory stands in for the external DRAM
	ufiFrameRam ram_i (
		.iClk     (iClk),
		.rstN     (rstN),
		.ufiReq   (ufiReq),
		.ufiReady (ufiReady),
		.ufiResp  (ufiResp)
	);

endmodule

`default_nettype wire

// File: videoDma_assertions.sv
// Video DMA engine checker for credit bound, request hold and reset output rules
`timescale 1ns/1ps
`default_nettype none

module videoDma_assertions
	import videoDmaPkg::*;
(
	input wire             iClk,
	input wire             rstN,
	input wire credit_t    credits,   // Engine credit counter
	input wire ufiReq_t    ufiReq,
	input wire             ufiReady,
	input wire pixelBeat_t pixOut
);

	int failCount = 0;   // Assertion failures so far

	// ------------------------------------------------------------------------
	// Credit bound
	// ------------------------------------------------------------------------
	creditBound: assert property (
		@(posedge iClk) disable iff (!rstN)
		credits <= credit_t'(creditMax)
	) else
	begin
		$error("credit counter above the sink limit");
		failCount++;
	end

	// A stalled request must not change until the RAM takes it
	reqHeld: assert property (
		@(posedge iClk) disable iff (!rstN)
		(ufiReq.valid && !ufiReady) |=> $stable(ufiReq)
	) else
	begin
		$error("UFI request changed while ready was low");
		failCount++;
	end

	// No output beat while in reset
	quietInReset: assert property (
		@(posedge iClk)
		!rstN |-> !pixOut.valid
	) else
	begin
		$error("pixOut valid during reset");
		failCount++;
	end

endmodule

`default_nettype wire

// File: videoDmaTb.sv
// Video DMA testbench running directed tests against the full subsystem
`timescale 1ns/1ps
`default_nettype none

module videoDmaTb
	import videoDmaPkg::*;
;

	localparam int cycleLimit = 20000;   // Six tests of up to ~2000 cycles, with margin

	logic       iClk = 1'b0;
	logic       rstN;
	pixelBeat_t pixIn;
	logic       pixInFull;
	logic       regWe;
	regAddr_t   regAddr;
	regData_t   regWdata;
	regData_t   regRdata;
	pixelBeat_t pixOut;
	logic       creditReturn = 1'b0;

	logic [31:0] rngState = 32'h5b282989;
	pixel_t      sentPix [$];            // Every pixel pushed in the current test
	pixel_t      gotPix [$];             // Sink receive log
	logic [2:0]  delayLine;              // Credit return delay
	int          owed;
	int          manualCredits = 0;
	logic        holdCredits = 1'b0;
	int          errors = 0;
	int          tests = 0;
	int          cycles = 0;

	videoDmaTop dut_i (
		.iClk         (iClk),
		.rstN         (rstN),
		.pixIn        (pixIn),
		.pixInFull    (pixInFull),
		.regWe        (regWe),
		.regAddr      (regAddr),
		.regWdata     (regWdata),
		.regRdata     (regRdata),
		.pixOut       (pixOut),
		.creditReturn (creditReturn)
	);

	bind videoDmaEngine videoDma_assertions asrt_i (
		.iClk     (iClk),
		.rstN     (rstN),
		.credits  (credits),
		.ufiReq   (ufiReq),
		.ufiReady (ufiReady),
		.pixOut   (pixOut)
	);

	always #2 iClk = !iClk;             // 4 ns period

	always @(posedge iClk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("Run stopped: cycle limit of %0d reached", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Display sink model
	// ------------------------------------------------------------------------
	always @(negedge iClk)
	begin
		if (!rstN)
		begin
			delayLine    = '0;
			owed         = 0;
			creditReturn = 1'b0;
		end
		else
		begin
			if (pixOut.valid)
				gotPix.push_back(pixOut.data);
			if (delayLine[2] && !holdCredits)
				owed = owed + 1;             // Withheld beats are never credited
			delayLine = {delayLine[1:0], pixOut.valid};
			if (manualCredits > 0)
			begin
				creditReturn  = 1'b1;
				manualCredits = manualCredits - 1;
			end
			else if (owed > 0)
			begin
				creditReturn = 1'b1;
				owed         = owed - 1;
			end
			else
				creditReturn = 1'b0;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic checkPixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkReg(input string name, input regData_t got, input regData_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Bus and stream helpers
	// ------------------------------------------------------------------------
	task automatic applyReset();
		@(negedge iClk);
		rstN        = 1'b0;
		pixIn       = '0;
		regWe       = 1'b0;
		holdCredits = 1'b0;
		repeat (4) @(negedge iClk);
		gotPix.delete();
		sentPix.delete();
		rstN = 1'b1;
	endtask

	task automatic writeReg(input regAddr_t a, input regData_t d);
		@(negedge iClk);
		regWe    = 1'b1;
		regAddr  = a;
		regWdata = d;
		@(negedge iClk);
		regWe = 1'b0;
	endtask

	task automatic readReg(input regAddr_t a, output regData_t d);
		@(negedge iClk);
		regAddr = a;
		@(negedge iClk);
		d = regRdata;                       // Settled for half a cycle
	endtask

	task automatic setupFrame(input int len);
		writeReg(regBase0, 32'd0);
		writeReg(regBase1, 32'd256);
		writeReg(regFrameLen, regData_t'(len));
		writeReg(regCtrl, 32'd1);
	endtask

	task automatic pushPixels(input int n);
		int i;
		i = 0;
		while (i < n)
		begin
			@(negedge iClk);
			if (!pixInFull)
			begin
				rngState = xorshift(rngState);
				pixIn    = '{valid: 1'b1, data: rngState[15:0]};
				sentPix.push_back(rngState[15:0]);
				i++;
			end
			else
				pixIn.valid = 1'b0;          // Producer stalls
		end
		@(negedge iClk);
		pixIn = '0;
	endtask

	task automatic waitBeats(input int n, input int limit);
		int c;
		c = 0;
		while (gotPix.size() < n && c < limit)
		begin
			@(negedge iClk);
			c++;
		end
		if (gotPix.size() < n)
		begin
			$display("Error at %0t: only %0d of %0d output beats arrived",
				$time, gotPix.size(), n);
			errors++;
		end
	endtask

	task automatic waitFrameCount(input int n, input int limit);
		regData_t d;
		int       c;
		c = 0;
		readReg(regStatus, d);
		while (int'(d[15:8]) < n && c < limit)
		begin
			readReg(regStatus, d);
			c++;
		end
		if (int'(d[15:8]) < n)
		begin
			$display("Error at %0t: frame count stuck at %0d, wanted %0d", $time, d[15:8], n);
			errors++;
		end
	endtask

	// Beat start+k must equal pushed pixel off + k mod len
	task automatic checkStream(input int start, input int off, input int n, input int len);
		for (int k = 0; k < n; k++)
		begin
			if (start + k < gotPix.size())
				checkPixel($sformatf("pixOut.data[%0d]", start + k), gotPix[start + k],
					sentPix[off + (k % len)]);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		tests++;
		$display("%s: %s", name, (errors == errBefore) ? "pass" : "fail");
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic testResetRegs();
		regData_t d;
		int       e;
		e = errors;
		applyReset();
		checkFlag("pixOut.valid", pixOut.valid, 1'b0);
		readReg(regStatus, d);
		checkReg("status", d, 32'd0);
		setupFrame(32);
		readReg(regBase0, d);
		checkReg("base0", d, 32'd0);
		readReg(regBase1, d);
		checkReg("base1", d, 32'd256);
		readReg(regFrameLen, d);
		checkReg("frameLen", d, 32'd32);
		writeReg(3'd6, 32'hffff_ffff);      // Unmapped
		readReg(3'd6, d);
		checkReg("reg6", d, 32'd0);
		reportTest("reset and registers", e);
	endtask

	task automatic testRoundTrip();
		regData_t d;
		int       e;
		e = errors;
		applyReset();
		setupFrame(32);
		pushPixels(32);
		waitFrameCount(1, 500);
		readReg(regStatus, d);
		// One frame done, writing buffer 1, reading buffer 0
		checkReg("status", d, 32'h0000_0101);
		waitBeats(96, 2000);
		checkStream(0, 0, 96, 32);          // Three passes over the frame
		reportTest("single-frame round trip", e);
	endtask

	task automatic testCreditLimit();
		int e;
		e = errors;
		applyReset();
		holdCredits = 1'b1;
		setupFrame(32);
		pushPixels(32);
		waitBeats(creditMax, 500);
		repeat (100) @(negedge iClk);
		checkReg("beat count", regData_t'(gotPix.size()), regData_t'(creditMax));
		manualCredits = manualCredits + 3;
		waitBeats(creditMax + 3, 200);
		repeat (50) @(negedge iClk);
		checkReg("beat count", regData_t'(gotPix.size()), regData_t'(creditMax + 3));
		checkStream(0, 0, creditMax + 3, 32);
		reportTest("credit limit", e);
	endtask

	task automatic testDoubleBuffer();
		regData_t d;
		int       e;
		int       start;
		e = errors;
		applyReset();
		setupFrame(32);
		pushPixels(32);                     // Frame A
		pushPixels(32);                     // Frame B
		waitFrameCount(2, 1000);
		readReg(regStatus, d);
		checkReg("status.frameCount/writeSel", d & 32'h0000_ff01, 32'h0000_0200);
		// Reads in flight may still belong to frame A
		start = ((gotPix.size() + creditMax + 2 + 31) / 32) * 32;
		waitBeats(start + 32, 2000);
		checkStream(start, 32, 32, 32);
		reportTest("double buffering", e);
	endtask

	task automatic testBackPressure();
		int e;
		int n;
		e = errors;
		n = 0;
		applyReset();
		while (n < 40)
		begin
			@(negedge iClk);
			if (pixInFull)
			begin
				pixIn = '0;
				break;
			end
			rngState = xorshift(rngState);
			pixIn    = '{valid: 1'b1, data: rngState[15:0]};
			sentPix.push_back(rngState[15:0]);
			n++;
		end
		checkReg("beats until full", regData_t'(n), regData_t'(fifoDepth));
		repeat (2) @(negedge iClk);
		checkFlag("pixInFull", pixInFull, 1'b1);
		setupFrame(16);
		waitFrameCount(1, 500);
		checkFlag("pixInFull", pixInFull, 1'b0);
		waitBeats(32, 1000);
		checkStream(0, 0, 32, 16);
		reportTest("FIFO back-pressure", e);
	endtask

	task automatic testDisable();
		regData_t d;
		int       e;
		int       base;
		int       off;
		e = errors;
		applyReset();
		setupFrame(32);
		pushPixels(32);
		waitBeats(40, 1000);
		writeReg(regCtrl, 32'd0);
		@(negedge iClk);
		checkFlag("pixOut.valid", pixOut.valid, 1'b0);
		base = gotPix.size();
		readReg(regStatus, d);
		checkReg("status", d, 32'd0);
		repeat (50) @(negedge iClk);
		checkReg("beat count", regData_t'(gotPix.size()), regData_t'(base));
		writeReg(regCtrl, 32'd1);
		repeat (100) @(negedge iClk);       // No frame yet, no output
		checkReg("beat count", regData_t'(gotPix.size()), regData_t'(base));
		off = sentPix.size();
		pushPixels(32);
		waitFrameCount(1, 500);
		waitBeats(base + 32, 1000);
		checkStream(base, off, 32, 32);
		reportTest("disable clears state", e);
	endtask

	initial
	begin
		rstN     = 1'b0;
		pixIn    = '0;
		regWe    = 1'b0;
		regAddr  = '0;
		regWdata = '0;
		testResetRegs();
		testRoundTrip();
		testCreditLimit();
		testDoubleBuffer();
		testBackPressure();
		testDisable();
		errors = errors + dut_i.engine_i.asrt_i.failCount;  // Bound checker failures
		$display("Tests run: %0d, errors: %0d, cycles: %0d", tests, errors, cycles);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: videoDmaTop.f
videoDmaPkg.sv
pixelWriteFifo.sv
dmaConfigRegs.sv
videoDmaEngine.sv
ufiFrameRam.sv
videoDmaTop.sv
videoDma_assertions.sv
videoDmaTb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f videoDmaTop.f --top-module videoDmaTb -Mdir obj_dir

run: build
	./obj_dir/VvideoDmaTb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q -e "TESTBENCH FAILED" -e "%Error" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f videoDmaTop.f --top-module videoDmaTb

clean:
	rm -rf obj_dir sim.log
